/* virtual_icmu.f */
rtl/vicmu_pkg.sv
rtl/guest_int_bank.sv
rtl/guest_switch_seq.sv
rtl/virtual_icmu.sv
sim/virtual_icmu_assertions.sv
sim/tb_virtual_icmu.sv

/* Makefile */
# Verilator build and run for the virtual interrupt controller testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_virtual_icmu
FILELIST  ?= virtual_icmu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

SOURCES := $(shell cat $(FILELIST))
SIM_EXE := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit status does not.
run: compile
	./$(SIM_EXE) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_virtual_icmu.sv */
// Random-stimulus testbench for the virtual interrupt controller with a cycle reference model.
`timescale 1ns/1ps

module tb_virtual_icmu
    import vicmu_pkg::*;
;

    localparam int random_cycles  = 2000;
    localparam int masked_cycles  = 20;
    localparam int timeout_cycles = 2500;

    logic                                 clk;
    logic                                 rst_n;
    logic [num_guests*ints_per_guest-1:0] phys_int;
    logic                                 guest_switch_req;
    logic [guest_w-1:0]                   active_guest;
    logic                                 cfg_we;
    logic                                 cfg_op;
    logic [guest_w-1:0]                   cfg_guest;
    cfg_word_u                            cfg_wdata;
    logic [num_guests*int_id_w-1:0]       guest_int_id;
    logic [num_guests-1:0]                int_pending_guest;
    logic [guest_w-1:0]                   current_guest;
    logic                                 guest_switch_done;

    int seed = 39897;
    int cycle_count = 0;
    int error_count = 0;

    // Reference state.
    logic [ints_per_guest-1:0] m_pend [num_guests];
    logic [ints_per_guest-1:0] m_mask [num_guests];
    logic [int_id_w-1:0]       exp_id [num_guests];
    logic                      exp_flag [num_guests];
    logic [guest_w-1:0]        exp_cur;
    logic [guest_w-1:0]        seq_target;
    logic                      exp_done;
    int                        seq_step;

    virtual_icmu i_virtual_icmu (.*);

    bind virtual_icmu virtual_icmu_assertions u_assertions (
        .clk               (clk),
        .rst_n             (rst_n),
        .guest_switch_req  (guest_switch_req),
        .seq_state         (u_seq.state),
        .guest_int_id      (guest_int_id),
        .int_pending_guest (int_pending_guest),
        .current_guest     (current_guest),
        .guest_switch_done (guest_switch_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Flag in bit 3, id in bits 2:0. Id holds when nothing is unmasked.
    function automatic logic [3:0] bank_result(
        input logic [ints_per_guest-1:0] pend,
        input logic [ints_per_guest-1:0] msk,
        input logic [int_id_w-1:0]       prev_id
    );
        logic [ints_per_guest-1:0] live;
        logic [3:0]                res;
        live = pend & ~msk;
        res  = {1'b0, prev_id};
        for (int i = ints_per_guest - 1; i >= 0; i--) begin
            if (live[i] && !res[3]) begin
                res = {1'b1, 3'(i)};
            end
        end
        return res;
    endfunction

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s got %0h, expected %0h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic drive_inputs(input bit allow_cfg);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        r4 = $random(seed);
        phys_int         = r1[15:0] & r2[15:0] & r3[15:0] & r4[15:0];
        cfg_we           = allow_cfg && r4[16];
        cfg_op           = r4[17];
        cfg_guest        = r4[18];
        guest_switch_req = allow_cfg && (r4[31:28] == 4'h0);
        active_guest     = r4[27];
        if (cfg_op == cfg_op_eoi) begin
            cfg_wdata.eoi.rsvd = '0;
            cfg_wdata.eoi.id   = r4[21:19];
            // Sometimes hit the line being cleared on the same edge.
            if (r4[24:22] == 3'b000) begin
                phys_int[int'(r4[18]) * ints_per_guest + int'(r4[21:19])] = 1'b1;
            end
        end else begin
            cfg_wdata.mask = r3[23:16];
        end
    endtask

    // ##################################################
    // Stimulus
    // ##################################################
    initial begin
        rst_n            = 1'b0;
        phys_int         = '0;
        guest_switch_req = 1'b0;
        active_guest     = '0;
        cfg_we           = 1'b0;
        cfg_op           = cfg_op_mask;
        cfg_guest        = '0;
        cfg_wdata        = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Masks still all ones, nothing may show.
        repeat (masked_cycles) begin
            @(negedge clk);
            drive_inputs(1'b0);
        end
        repeat (random_cycles) begin
            @(negedge clk);
            drive_inputs(1'b1);
        end
        @(negedge clk);
        cfg_we           = 1'b0;
        guest_switch_req = 1'b0;
        phys_int         = '0;
        repeat (8) @(negedge clk);
        if (error_count == 0 && i_virtual_icmu.u_assertions.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // ##################################################
    // Reference model and comparison
    // ##################################################
    initial begin
        logic [ints_per_guest-1:0] clr;
        logic [3:0]                res;
        for (int g = 0; g < num_guests; g++) begin
            m_pend[g]   = '0;
            m_mask[g]   = '1;
            exp_id[g]   = '0;
            exp_flag[g] = 1'b0;
        end
        exp_cur  = '0;
        exp_done = 1'b0;
        seq_step = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            for (int g = 0; g < num_guests; g++) begin
                res         = bank_result(m_pend[g], m_mask[g], exp_id[g]);
                exp_flag[g] = res[3];
                exp_id[g]   = res[2:0];
                clr = '0;
                if (cfg_we && cfg_guest == guest_w'(g)) begin
                    if (cfg_op == cfg_op_eoi) begin
                        clr[cfg_wdata.eoi.id] = 1'b1;
                    end else begin
                        m_mask[g] = cfg_wdata.mask;
                    end
                end
                m_pend[g] = (m_pend[g] & ~clr) | phys_int[g*ints_per_guest +: ints_per_guest];
            end
            // Switch steps: 0 idle, 1 save, 2 pending, 3 restore, 4 done.
            exp_done = (seq_step == 4);
            if (seq_step == 4) begin
                exp_cur  = seq_target;
                seq_step = 0;
            end else if (seq_step == 0) begin
                if (guest_switch_req) begin
                    seq_target = active_guest;
                    seq_step   = 1;
                end
            end else begin
                seq_step++;
            end
            #2;
            for (int g = 0; g < num_guests; g++) begin
                check_value(8'(int_pending_guest[g]), 8'(exp_flag[g]), "int_pending_guest");
                check_value(8'(guest_int_id[g*int_id_w +: int_id_w]), 8'(exp_id[g]),
                            "guest_int_id");
            end
            check_value(8'(guest_switch_done), 8'(exp_done), "guest_switch_done");
            check_value(8'(current_guest), 8'(exp_cur), "current_guest");
            if (i_virtual_icmu.u_assertions.fail_count != 0) begin
                $display("A concurrent assertion on the DUT failed at %0t ns", $time);
                $display("Verification failed");
                $fatal(1, "Assertion failure");
            end
        end
    end

    // Run limit.
    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Verification failed");
        $fatal(1, "Timeout");
    end

endmodule

/* sim/virtual_icmu_assertions.sv */
// Concurrent checks on the virtual interrupt controller top level, bound in from the testbench.
`timescale 1ns/1ps

module virtual_icmu_assertions
    import vicmu_pkg::*;
(
    input logic                           clk,
    input logic                           rst_n,
    input logic                           guest_switch_req,
    input logic [2:0]                     seq_state,
    input logic [num_guests*int_id_w-1:0] guest_int_id,
    input logic [num_guests-1:0]          int_pending_guest,
    input logic [guest_w-1:0]             current_guest,
    input logic                           guest_switch_done
);

    // Number of failed assertions so far.
    int fail_count = 0;

    // ##################################################
    // Switch handshake timing
    // ##################################################
    // Done is a single-cycle pulse.
    done_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        guest_switch_done |=> !guest_switch_done
    ) else begin
        fail_count++;
        $error("guest_switch_done held for more than one cycle");
    end

    // Accepted request to done, counted in sampled edges.
    done_after_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        (seq_state == seq_idle && guest_switch_req)
            |-> ##1 (!guest_switch_done) [*4] ##1 guest_switch_done
    ) else begin
        fail_count++;
        $error("guest_switch_done not seen five edges after an accepted request");
    end

    // ##################################################
    // Known outputs
    // ##################################################
    outputs_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({guest_int_id, int_pending_guest, current_guest, guest_switch_done})
    ) else begin
        fail_count++;
        $error("Unknown value on a top level output");
    end

endmodule

/* rtl/virtual_icmu.sv */
// Top level of the virtual interrupt controller: one bank per guest plus the switch sequencer.
`timescale 1ns/1ps

module virtual_icmu
    import vicmu_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [num_guests*ints_per_guest-1:0] phys_int,
    input  logic                                 guest_switch_req,
    input  logic [guest_w-1:0]                   active_guest,
    input  logic                                 cfg_we,
    input  logic                                 cfg_op,
    input  logic [guest_w-1:0]                   cfg_guest,
    input  cfg_word_u                            cfg_wdata,
    output logic [num_guests*int_id_w-1:0]       guest_int_id,
    output logic [num_guests-1:0]                int_pending_guest,
    output logic [guest_w-1:0]                   current_guest,
    output logic                                 guest_switch_done
);

    // ##################################################
    // Interrupt banks
    // ##################################################
    // Every bank sees the shared write port and picks out its own writes.
    for (genvar g = 0; g < num_guests; g++) begin : g_bank
        guest_int_bank #(
            .bank_id (g)
        ) u_bank (
            .clk         (clk),
            .rst_n       (rst_n),
            .lines       (phys_int[g*ints_per_guest +: ints_per_guest]),
            .cfg_we      (cfg_we),
            .cfg_op      (cfg_op),
            .cfg_guest   (cfg_guest),
            .cfg_wdata   (cfg_wdata),
            .int_id      (guest_int_id[g*int_id_w +: int_id_w]),
            .int_pending (int_pending_guest[g])
        );
    end

    // ##################################################
    // Guest switch
    // ##################################################
    guest_switch_seq u_seq (
        .clk               (clk),
        .rst_n             (rst_n),
        .guest_switch_req  (guest_switch_req),
        .active_guest      (active_guest),
        .current_guest     (current_guest),
        .guest_switch_done (guest_switch_done)
    );

endmodule

/* rtl/guest_switch_seq.sv */
// Guest-switch FSM that steps save, pending and restore phases and commits the new guest.
`timescale 1ns/1ps

module guest_switch_seq
    import vicmu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               guest_switch_req,
    input  logic [guest_w-1:0] active_guest,
    output logic [guest_w-1:0] current_guest,
    output logic               guest_switch_done
);

    logic [2:0]         state;
    logic [2:0]         state_next;
    logic [guest_w-1:0] target_guest;
    logic               accept;

    // Requests only count in idle.
    assign accept = (state == seq_idle) && guest_switch_req;

    // ##################################################
    // Next state
    // ##################################################
    always_comb begin
        case (state)
            seq_idle:    state_next = guest_switch_req ? seq_save : seq_idle;
            seq_save:    state_next = seq_pending;
            seq_pending: state_next = seq_restore;
            seq_restore: state_next = seq_done;
            seq_done:    state_next = seq_idle;
            default:     state_next = seq_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= seq_idle;
        end else begin
            state <= state_next;
        end
    end

    // Target guest, captured with the request.
    always_ff @(posedge clk) begin
        if (accept) begin
            target_guest <= active_guest;
        end
    end

    // ##################################################
    // Commit and done pulse
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_guest     <= '0;
            guest_switch_done <= 1'b0;
        end else begin
            guest_switch_done <= (state == seq_done);
            if (state == seq_done) begin
                current_guest <= target_guest;
            end
        end
    end

endmodule

/* rtl/guest_int_bank.sv */
// Per-guest pending and mask registers with a registered highest-line interrupt id.
`timescale 1ns/1ps

module guest_int_bank
    import vicmu_pkg::*;
#(
    parameter int bank_id = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [ints_per_guest-1:0] lines,
    input  logic                      cfg_we,
    input  logic                      cfg_op,
    input  logic [guest_w-1:0]        cfg_guest,
    input  cfg_word_u                 cfg_wdata,
    output logic [int_id_w-1:0]       int_id,
    output logic                      int_pending
);

    logic [ints_per_guest-1:0] pending;
    logic [ints_per_guest-1:0] mask;
    logic [ints_per_guest-1:0] unmasked;
    logic [ints_per_guest-1:0] eoi_clear;
    logic                      cfg_hit;
    logic                      mask_wr;
    logic                      eoi_wr;

    // Highest set bit wins.
    function automatic logic [int_id_w-1:0] highest_line(
        input logic [ints_per_guest-1:0] vec
    );
        logic [int_id_w-1:0] id;
        id = '0;
        for (int i = 0; i < ints_per_guest; i++) begin
            if (vec[i]) begin
                id = int_id_w'(i);
            end
        end
        return id;
    endfunction

    // ##################################################
    // Configuration decode
    // ##################################################
    assign cfg_hit = cfg_we && (cfg_guest == guest_w'(bank_id));
    assign mask_wr = cfg_hit && (cfg_op == cfg_op_mask);
    assign eoi_wr  = cfg_hit && (cfg_op == cfg_op_eoi);

    always_comb begin
        eoi_clear = '0;
        if (eoi_wr) begin
            eoi_clear[cfg_wdata.eoi.id] = 1'b1;
        end
    end

    assign unmasked = pending & ~mask;

    // ##################################################
    // State registers
    // ##################################################
    // A line asserted on the same edge as its EOI stays pending.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~eoi_clear) | lines;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '1;
        end else if (mask_wr) begin
            mask <= cfg_wdata.mask;
        end
    end

    // Outputs lag the pending and mask state by one edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_pending <= 1'b0;
            int_id      <= '0;
        end else begin
            int_pending <= |unmasked;
            // Id keeps its last value while nothing is unmasked.
            if (|unmasked) begin
                int_id <= highest_line(unmasked);
            end
        end
    end

endmodule

/* rtl/vicmu_pkg.sv */
// Shared sizes, sequencer states and configuration word layout for the virtual interrupt controller.
package vicmu_pkg;

    // ##################################################
    // Sizes
    // ##################################################
    localparam int num_guests     = 2;
    localparam int ints_per_guest = 8;
    localparam int int_id_w       = 3;
    localparam int guest_w        = 1;

    // ##################################################
    // Guest-switch sequencer states
    // ##################################################
    localparam logic [2:0] seq_idle    = 3'b000;
    localparam logic [2:0] seq_save    = 3'b001;
    localparam logic [2:0] seq_pending = 3'b010;
    localparam logic [2:0] seq_restore = 3'b011;
    localparam logic [2:0] seq_done    = 3'b100;

    // ##################################################
    // Configuration port
    // ##################################################
    localparam logic cfg_op_mask = 1'b0;
    localparam logic cfg_op_eoi  = 1'b1;

    // Same data byte, read as a full mask or as an EOI line number.
    typedef union packed {
        logic [ints_per_guest-1:0] mask;
        struct packed {
            logic [ints_per_guest-int_id_w-1:0] rsvd;
            logic [int_id_w-1:0]                id;
        } eoi;
    } cfg_word_u;

endpackage
